//--- sim.f
common/tcb_pkg.sv
hdl/tcb_lane_converter.sv
hdl/tcb_misalign_gate.sv
tcb_memory/tcb_memory.sv
hdl/tcb_subsystem_top.sv
bench/tcb_tb_chk.sv
bench/tcb_tb.sv

//--- bench/tcb_input.txt
# wen ndn siz adr wdt exp_rdt exp_err, all hex, one access per line
# ndn 1 is big endian, siz is log2 of the size in bytes
1 0 2 0000 11223344 00000000 0
0 0 2 0000 00000000 11223344 0
0 1 2 0000 00000000 44332211 0
1 1 2 0004 AABBCCDD 00000000 0
0 0 2 0004 00000000 DDCCBBAA 0
0 1 2 0004 00000000 AABBCCDD 0
1 0 2 0008 00000000 00000000 0
1 0 0 0008 000000A1 00000000 0
1 1 0 0009 FFFFFFB2 00000000 0
1 0 0 000A 123456C3 00000000 0
0 0 2 0008 00000000 00C3B2A1 0
1 1 0 000B 000000D4 00000000 0
0 0 2 0008 00000000 D4C3B2A1 0
1 0 2 000C 00000000 00000000 0
1 0 1 000C 99995A6B 00000000 0
1 1 1 000E 0000C1D2 00000000 0
0 0 2 000C 00000000 D2C15A6B 0
1 1 1 000C 00001234 00000000 0
0 0 2 000C 00000000 D2C13412 0
0 0 0 0009 00000000 000000B2 0
0 1 0 000B 00000000 000000D4 0
0 0 1 000A 00000000 0000D4C3 0
0 1 1 000A 00000000 0000C3D4 0
0 0 1 0008 00000000 0000B2A1 0
0 1 1 000C 00000000 00001234 0
1 0 1 0005 0000EEEE 00000000 1
1 0 2 0006 FFFFFFFF 00000000 1
1 0 3 0004 FFFFFFFF 00000000 1
0 0 3 0000 00000000 00000000 1
0 0 2 0004 00000000 DDCCBBAA 0
0 1 1 0003 00000000 00000000 1
1 0 2 0010 CAFEF00D 00000000 0
0 0 1 0011 00000000 00000000 1
0 0 2 0010 00000000 CAFEF00D 0
1 0 0 0103 00000055 00000000 0
0 0 2 0000 00000000 55223344 0
0 1 0 0013 00000000 000000CA 0

//--- bench/tcb_tb.sv
/*
  TCB subsystem testbench. Reads access vectors from a file, issues one
  request per cycle and checks responses in order against expected values
*/

`timescale 1ns/1ps

module tcb_tb;

  localparam int unsigned DLY       = 2;
  localparam int unsigned MEM_WORDS = 64;
  localparam int unsigned CLK_NS    = 20;

  logic                  clk;
  logic                  reset;
  logic                  req_vld;
  tcb_pkg::tcb_req_ref_t req;
  logic                  req_rdy;
  logic                  rsp_vld;
  tcb_pkg::tcb_rsp_t     rsp;

  // vectors from the file
  tcb_pkg::tcb_req_ref_t vec_req [$];
  tcb_pkg::tcb_rsp_t     vec_rsp [$];
  int                    n_vec;
  // responses still owed and their vector numbers
  tcb_pkg::tcb_rsp_t     exp_q [$];
  int                    idx_q [$];
  int                    cur_idx;
  bit                    loaded;
  bit                    ok;
  int                    n_rdt_err;
  int                    n_err_err;
  int                    n_seq_err;

  tcb_subsystem_top #(
    .DLY       (DLY),
    .MEM_WORDS (MEM_WORDS)
  ) i_dut (
    .clk     (clk),
    .reset   (reset),
    .req_vld (req_vld),
    .req     (req),
    .req_rdy (req_rdy),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

  bind tcb_subsystem_top tcb_tb_chk #(.DLY(DLY)) i_chk (
    .clk     (clk),
    .reset   (reset),
    .req_vld (req_vld),
    .req     (req),
    .req_rdy (req_rdy),
    .rsp_vld (rsp_vld)
  );

  initial clk = 1'b0;
  always #(CLK_NS / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // vector file and compare tasks
  //////////////////////////////////////////////////

  // one access per line in hex
  // comment lines fail to parse and are skipped
  task automatic load_vectors(output bit status);
    int                    fd;
    int                    code;
    logic [8*128-1:0]      line_buf;
    logic [31:0]           f_wen, f_ndn, f_siz, f_adr, f_wdt, f_rdt, f_err;
    tcb_pkg::tcb_req_ref_t r;
    tcb_pkg::tcb_rsp_t     s;
    status = 1'b0;
    fd = $fopen("bench/tcb_input.txt", "r");
    if (fd != 0) begin
      line_buf = '0;
      code = $fgets(line_buf, fd);
      while (code != 0) begin
        if ($sscanf(line_buf, "%h %h %h %h %h %h %h",
                    f_wen, f_ndn, f_siz, f_adr, f_wdt, f_rdt, f_err) == 7) begin
          r.wen = f_wen[0];
          r.ndn = f_ndn[0];
          r.siz = tcb_pkg::tcb_siz_t'(f_siz);
          r.adr = tcb_pkg::tcb_adr_t'(f_adr);
          r.wdt = tcb_pkg::tcb_dat_t'(f_wdt);
          s.rdt = tcb_pkg::tcb_dat_t'(f_rdt);
          s.err = f_err[0];
          vec_req.push_back(r);
          vec_rsp.push_back(s);
        end
        line_buf = '0;
        code = $fgets(line_buf, fd);
      end
      $fclose(fd);
      status = (vec_req.size() > 0);
    end
  endtask

  task automatic check_rdt(input string name, input tcb_pkg::tcb_dat_t exp,
                           input tcb_pkg::tcb_dat_t act);
    if (act !== exp) begin
      $display("[ERROR] %s rdt: expected %h, actual %h", name, exp, act);
      n_rdt_err++;
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s err: expected %b, actual %b", name, exp, act);
      n_err_err++;
    end
  endtask

  //////////////////////////////////////////////////
  // response monitor
  //////////////////////////////////////////////////

  // responses pop before this edge's handshake pushes
  always @(posedge clk) begin : monitor
    tcb_pkg::tcb_rsp_t exp_rsp;
    int                exp_i;
    if (!reset) begin
      if (rsp_vld) begin
        if (exp_q.size() == 0) begin
          $display("response at %0t with no request outstanding", $time);
          n_seq_err++;
        end else begin
          exp_rsp = exp_q.pop_front();
          exp_i   = idx_q.pop_front();
          check_rdt($sformatf("vector %0d", exp_i), exp_rsp.rdt, rsp.rdt);
          check_err($sformatf("vector %0d", exp_i), exp_rsp.err, rsp.err);
        end
      end
      if (req_vld && req_rdy) begin
        exp_q.push_back(vec_rsp[cur_idx]);
        idx_q.push_back(cur_idx + 1);
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    reset     = 1'b1;
    req_vld   = 1'b0;
    req       = '0;
    cur_idx   = 0;
    loaded    = 1'b0;
    n_rdt_err = 0;
    n_err_err = 0;
    n_seq_err = 0;
    load_vectors(ok);
    if (!ok) begin
      $display("no vectors could be read from bench/tcb_input.txt");
      $display("Simulation failed");
      $finish;
    end else begin
      n_vec  = vec_req.size();
      loaded = 1'b1;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      // one request per cycle
      for (int i = 0; i < n_vec; i++) begin
        @(posedge clk);
        req_vld <= 1'b1;
        req     <= vec_req[i];
        cur_idx <= i;
      end
      @(posedge clk);
      req_vld <= 1'b0;
      req     <= '0;
      // drain and wait a little longer for stray responses
      while (exp_q.size() != 0) @(posedge clk);
      repeat (2) @(posedge clk);
      $display("errors: rdt %0d, err %0d, sequence %0d, assertion %0d",
               n_rdt_err, n_err_err, n_seq_err, i_dut.i_chk.n_fail);
      if (n_rdt_err + n_err_err + n_seq_err + i_dut.i_chk.n_fail == 0) begin
        $display("Simulation completed successfully");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

  // watchdog sized from the vector count
  initial begin
    wait (loaded);
    #((n_vec + DLY + 10) * CLK_NS);
    $display("timeout with %0d responses still outstanding", exp_q.size());
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- bench/tcb_tb_chk.sv
/*
  TCB protocol checker bound to the subsystem top. Checks request
  stability, a quiet response during reset and the response DLY cycles
  after each handshake
*/

`timescale 1ns/1ps

module tcb_tb_chk #(
  parameter int unsigned DLY = 1
)(
  input logic                  clk,
  input logic                  reset,
  input logic                  req_vld,
  input tcb_pkg::tcb_req_ref_t req,
  input logic                  req_rdy,
  input logic                  rsp_vld
);

  // assertion failures so far
  int n_fail;

  // request held while stalled
  a_req_stable: assert property (@(posedge clk) disable iff (reset)
    (req_vld && !req_rdy) |=> $stable(req))
    else begin
      n_fail++;
      $error("request changed while stalled");
    end

  // no response while reset is held
  a_rsp_reset: assert property (@(posedge clk)
    (reset && $past(reset)) |-> !rsp_vld)
    else begin
      n_fail++;
      $error("response valid during reset");
    end

  // each handshake answered DLY cycles later
  a_rsp_after_hsk: assert property (@(posedge clk) disable iff (reset)
    (req_vld && req_rdy) |-> ##DLY rsp_vld)
    else begin
      n_fail++;
      $error("missing response DLY cycles after handshake");
    end

  // and no response without a handshake behind it
  a_rsp_has_hsk: assert property (@(posedge clk) disable iff (reset)
    rsp_vld |-> $past(req_vld && req_rdy, DLY))
    else begin
      n_fail++;
      $error("response without a matching handshake");
    end

endmodule

//--- hdl/tcb_subsystem_top.sv
/*
  TCB subsystem: lane converter, misalignment gate and byte-enabled
  memory behind one reference-mode subordinate port
*/

`timescale 1ns/1ps

module tcb_subsystem_top #(
  parameter int unsigned DLY       = 1,
  parameter int unsigned MEM_WORDS = 64
)(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req_vld,
  input  tcb_pkg::tcb_req_ref_t  req,
  output logic                   req_rdy,
  output logic                   rsp_vld,
  output tcb_pkg::tcb_rsp_t      rsp
);

  // converter to gate and memory
  tcb_pkg::tcb_req_mem_t mem_req;
  logic                  mal;
  logic                  mem_vld;
  logic                  mem_rdy;
  // memory and gate responses
  logic                  mem_rsp_vld;
  tcb_pkg::tcb_rsp_t     mem_rsp;
  tcb_pkg::tcb_rsp_t     gate_rsp;

  tcb_lane_converter #(
    .DLY (DLY)
  ) i_converter (
    .clk     (clk),
    .reset   (reset),
    .vld     (req_vld),
    .req     (req),
    .rdy     (req_rdy),
    .rsp     (rsp),
    .mem_req (mem_req),
    .mem_rdy (mem_rdy),
    .mem_rsp (gate_rsp),
    .mal     (mal)
  );

  tcb_misalign_gate #(
    .DLY (DLY)
  ) i_gate (
    .clk         (clk),
    .reset       (reset),
    .vld         (req_vld),
    .mal         (mal),
    .mem_vld     (mem_vld),
    .rsp_vld     (rsp_vld),
    .mem_rsp_vld (mem_rsp_vld),
    .mem_rsp     (mem_rsp),
    .rsp         (gate_rsp)
  );

  tcb_memory #(
    .DLY       (DLY),
    .MEM_WORDS (MEM_WORDS)
  ) i_memory (
    .clk     (clk),
    .reset   (reset),
    .vld     (mem_vld),
    .rdy     (mem_rdy),
    .req     (mem_req),
    .rsp_vld (mem_rsp_vld),
    .rsp     (mem_rsp)
  );

endmodule

//--- tcb_memory/tcb_memory.sv
/*
  Byte-enabled TCB memory subordinate, always ready, returning each
  response DLY cycles after its handshake
*/

`timescale 1ns/1ps

module tcb_memory #(
  parameter int unsigned DLY       = 1,
  parameter int unsigned MEM_WORDS = 64
)(
  input  logic                   clk,
  input  logic                   reset,
  // request
  input  logic                   vld,
  output logic                   rdy,
  input  tcb_pkg::tcb_req_mem_t  req,
  // response
  output logic                   rsp_vld,
  output tcb_pkg::tcb_rsp_t      rsp
);

  localparam int unsigned IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  tcb_pkg::tcb_dat_t mem [MEM_WORDS];

  logic              hsk;
  logic [IDX_W-1:0]  idx;
  logic [DLY-1:0]    vld_q;
  tcb_pkg::tcb_dat_t rdt_q [DLY];

  // at least one register stage between request and response
  if (DLY < 1) begin : g_dly_check
    $error("tcb_memory: DLY must be at least 1");
  end

  // no wait states
  assign rdy = 1'b1;
  assign hsk = vld & rdy;

  // word index, out of range addresses wrap around
  assign idx = IDX_W'((req.adr >> tcb_pkg::OFF_W) % MEM_WORDS);

  //////////////////////////////////////////////////
  // array access
  //////////////////////////////////////////////////

  // byte writes on enabled lanes only
  always_ff @(posedge clk) begin
    if (hsk && req.wen) begin
      for (int unsigned b = 0; b < tcb_pkg::BUS_BYTES; b++) begin
        if (req.ben[b]) begin
          mem[idx][8*b +: 8] <= req.wdt[8*b +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // response pipeline
  //////////////////////////////////////////////////

  // valid stages
  always_ff @(posedge clk) begin
    if (reset) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= hsk;
      for (int i = 1; i < DLY; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  // data stages, write responses carry zero
  always_ff @(posedge clk) begin
    rdt_q[0] <= req.wen ? '0 : mem[idx];
    for (int i = 1; i < DLY; i++) begin
      rdt_q[i] <= rdt_q[i-1];
    end
  end

  assign rsp_vld = vld_q[DLY-1];
  assign rsp.rdt = rdt_q[DLY-1];
  assign rsp.err = 1'b0;

endmodule

//--- hdl/tcb_misalign_gate.sv
/*
  TCB misalignment gate: blocks flagged requests from reaching the
  memory and answers them with an error response after DLY cycles,
  merged with the memory response stream
*/

`timescale 1ns/1ps

module tcb_misalign_gate #(
  parameter int unsigned DLY = 1
)(
  input  logic               clk,
  input  logic               reset,
  // request side
  input  logic               vld,
  input  logic               mal,
  output logic               mem_vld,
  // response side
  output logic               rsp_vld,
  input  logic               mem_rsp_vld,
  input  tcb_pkg::tcb_rsp_t  mem_rsp,
  output tcb_pkg::tcb_rsp_t  rsp
);

  // one mark per rejected handshake
  logic [DLY-1:0] rej_q;
  logic           rej;
  logic           rej_out;

  //////////////////////////////////////////////////
  // request gating
  //////////////////////////////////////////////////

  // only aligned requests reach the memory
  assign mem_vld = vld & ~mal;

  // memory never stalls, so each valid misaligned cycle is a handshake
  assign rej = vld & mal;

  //////////////////////////////////////////////////
  // error response timing
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      rej_q <= '0;
    end else begin
      rej_q[0] <= rej;
      for (int i = 1; i < DLY; i++) begin
        rej_q[i] <= rej_q[i-1];
      end
    end
  end

  assign rej_out = rej_q[DLY-1];

  //////////////////////////////////////////////////
  // response merge
  //////////////////////////////////////////////////

  // one handshake per slot, so the two sources never collide
  assign rsp_vld = rej_out | mem_rsp_vld;

  always_comb begin
    if (rej_out) begin
      rsp = tcb_pkg::tcb_rsp_t'{rdt: '0, err: 1'b1};
    end else begin
      rsp = mem_rsp;
    end
  end

endmodule

//--- hdl/tcb_lane_converter.sv
/*
  TCB reference-to-memory mode converter: steers write bytes onto lanes,
  builds byte enables, flags misaligned accesses and steers read data
  back into reference order DLY cycles later
*/

`timescale 1ns/1ps

module tcb_lane_converter #(
  parameter int unsigned DLY = 1
)(
  input  logic                   clk,
  input  logic                   reset,
  // subordinate side, reference mode
  input  logic                   vld,
  input  tcb_pkg::tcb_req_ref_t  req,
  output logic                   rdy,
  output tcb_pkg::tcb_rsp_t      rsp,
  // manager side, memory mode
  output tcb_pkg::tcb_req_mem_t  mem_req,
  input  logic                   mem_rdy,
  input  tcb_pkg::tcb_rsp_t      mem_rsp,
  // misaligned access
  output logic                   mal
);

  // request attributes needed to steer the read data back
  typedef struct packed {
    logic              ndn;
    tcb_pkg::tcb_siz_t siz;
    tcb_pkg::tcb_off_t off;
  } ctx_t;

  ctx_t ctx_q [DLY];
  ctx_t ctx_d;
  ctx_t ctx;
  logic hsk;

  // lane holding byte k of an access starting at offset off
  function automatic tcb_pkg::tcb_off_t lane_sel(
    input tcb_pkg::tcb_off_t off,
    input tcb_pkg::tcb_siz_t siz,
    input logic              ndn,
    input int unsigned       k
  );
    int unsigned num;
    num = 1 << siz;
    if (ndn) begin
      // big endian, most significant byte on the lowest lane
      lane_sel = tcb_pkg::tcb_off_t'(off + num - 1 - k);
    end else begin
      lane_sel = tcb_pkg::tcb_off_t'(off + k);
    end
  endfunction

  //////////////////////////////////////////////////
  // alignment check
  //////////////////////////////////////////////////

  // any address bit below the access size set
  always_comb begin
    case (req.siz)
      2'd0:    mal = 1'b0;
      2'd1:    mal = req.adr[0];
      2'd2:    mal = |req.adr[1:0];
      default: mal = 1'b1;  // 8 bytes never fit the 4-lane bus
    endcase
  end

  //////////////////////////////////////////////////
  // request steering
  //////////////////////////////////////////////////

  always_comb begin
    mem_req.wen = req.wen;
    // lane bits cleared
    mem_req.adr = req.adr & ~tcb_pkg::tcb_adr_t'(tcb_pkg::BUS_BYTES - 1);
    mem_req.ben = '0;
    mem_req.wdt = '0;
    for (int unsigned k = 0; k < tcb_pkg::BUS_BYTES; k++) begin
      if (k < (1 << req.siz)) begin
        mem_req.wdt[8*lane_sel(req.adr[tcb_pkg::OFF_W-1:0], req.siz, req.ndn, k) +: 8] =
          req.wdt[8*k +: 8];
        mem_req.ben[lane_sel(req.adr[tcb_pkg::OFF_W-1:0], req.siz, req.ndn, k)] = 1'b1;
      end
    end
  end

  // no back-pressure of our own
  assign rdy = mem_rdy;
  assign hsk = vld & mem_rdy;

  //////////////////////////////////////////////////
  // response context pipeline
  //////////////////////////////////////////////////

  // idle slots carry an all-zero context
  always_comb begin
    ctx_d = '0;
    if (hsk) begin
      ctx_d.ndn = req.ndn;
      ctx_d.siz = req.siz;
      ctx_d.off = req.adr[tcb_pkg::OFF_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DLY; i++) begin
        ctx_q[i] <= '0;
      end
    end else begin
      ctx_q[0] <= ctx_d;
      for (int i = 1; i < DLY; i++) begin
        ctx_q[i] <= ctx_q[i-1];
      end
    end
  end

  // context of the request answered this cycle
  assign ctx = ctx_q[DLY-1];

  //////////////////////////////////////////////////
  // read data return
  //////////////////////////////////////////////////

  // inverse mapping, bytes above the access size read as zero
  always_comb begin
    rsp.err = mem_rsp.err;
    rsp.rdt = '0;
    for (int unsigned k = 0; k < tcb_pkg::BUS_BYTES; k++) begin
      if (k < (1 << ctx.siz)) begin
        rsp.rdt[8*k +: 8] = mem_rsp.rdt[8*lane_sel(ctx.off, ctx.siz, ctx.ndn, k) +: 8];
      end
    end
  end

endmodule

//--- common/tcb_pkg.sv
/*
  TCB bus definitions shared by the converter, the misalignment gate
  and the memory: widths, vector types, request and response structs
*/

package tcb_pkg;

  //////////////////////////////////////////////////
  // bus geometry
  //////////////////////////////////////////////////

  // byte lanes on the 32-bit bus, little-endian lane numbering
  localparam int unsigned BUS_BYTES = 4;
  // byte address width
  localparam int unsigned ADR_W = 16;
  // data width
  localparam int unsigned DAT_W = 8 * BUS_BYTES;
  // lane offset width inside a word
  localparam int unsigned OFF_W = $clog2(BUS_BYTES);

  //////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////

  typedef logic [ADR_W-1:0] tcb_adr_t;
  typedef logic [DAT_W-1:0] tcb_dat_t;
  typedef logic [BUS_BYTES-1:0] tcb_ben_t;
  // log2 of access size in bytes, 3 never fits this bus
  typedef logic [1:0] tcb_siz_t;
  // low address bits selecting the starting lane
  typedef logic [OFF_W-1:0] tcb_off_t;

  //////////////////////////////////////////////////
  // request and response
  //////////////////////////////////////////////////

  // reference mode, data in the low bytes
  typedef struct packed {
    logic     wen;
    logic     ndn;  // 1 = big endian
    tcb_siz_t siz;
    tcb_adr_t adr;
    tcb_dat_t wdt;
  } tcb_req_ref_t;

  // memory mode, data on its lanes, word aligned address
  typedef struct packed {
    logic     wen;
    tcb_adr_t adr;
    tcb_ben_t ben;
    tcb_dat_t wdt;
  } tcb_req_mem_t;

  typedef struct packed {
    tcb_dat_t rdt;
    logic     err;
  } tcb_rsp_t;

endpackage
